// File: common/jtag_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the JTAG TAP controller
// Instruction codes, register widths, IDCODE value and TAP state encoding
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package jtag_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction register
    ////////////////////////////////////////////////////////////////////////////
    localparam int IR_LENGTH = 4;

    typedef logic [IR_LENGTH-1:0] tap_instr_t;

    // Supported instruction codes, anything else behaves as BYPASS
    localparam tap_instr_t INSTR_EXTEST         = 4'b0000;
    localparam tap_instr_t INSTR_SAMPLE_PRELOAD = 4'b0001;
    localparam tap_instr_t INSTR_IDCODE         = 4'b0010;
    localparam tap_instr_t INSTR_DEBUG          = 4'b1000;
    localparam tap_instr_t INSTR_BYPASS         = 4'b1111;

    // Loaded in capture_ir, alternating bits catch stuck-at faults on the chain
    localparam tap_instr_t IR_CAPTURE_VALUE = 4'b0101;

    ////////////////////////////////////////////////////////////////////////////
    // Device identification
    ////////////////////////////////////////////////////////////////////////////
    localparam int IDCODE_LENGTH = 32;

    typedef logic [IDCODE_LENGTH-1:0] idcode_t;

    // Bit 0 must be one per IEEE 1149.1
    localparam idcode_t IDCODE_VALUE = 32'h1a7ce0d3;

    ////////////////////////////////////////////////////////////////////////////
    // TAP controller states
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        test_logic_reset, run_test_idle,
        select_dr_scan, capture_dr, shift_dr, exit1_dr, pause_dr, exit2_dr, update_dr,
        select_ir_scan, capture_ir, shift_ir, exit1_ir, pause_ir, exit2_ir, update_ir
    } tap_state_t;

endpackage

`default_nettype wire

// File: common/tap_state_if.sv
////////////////////////////////////////////////////////////////////////////
// Decoded TAP state strobes, driven by the state machine
// and read by the instruction and data register blocks
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

interface tap_state_if;

    // One strobe per state of interest, high while the FSM sits there
    logic tlr;
    logic capture_ir;
    logic shift_ir;
    logic update_ir;
    logic capture_dr;
    logic shift_dr;
    logic pause_dr;
    logic update_dr;

    // State machine side
    modport fsm_mp (
        output tlr, capture_ir, shift_ir, update_ir,
        output capture_dr, shift_dr, pause_dr, update_dr
    );

    // Register block side
    modport reg_mp (
        input tlr, capture_ir, shift_ir, update_ir,
        input capture_dr, shift_dr, pause_dr, update_dr
    );

endinterface

`default_nettype wire

// File: tap/tap_fsm.sv
////////////////////////////////////////////////////////////////////////////
// Sixteen state IEEE 1149.1 TAP controller
// Steps on rising TCK following TMS, publishes state strobes on tap_state_if
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tap_fsm (
    input  logic        tck_pad_i,
    input  logic        trst_pad_i,
    input  logic        tms_pad_i,
    tap_state_if.fsm_mp state
);

    import jtag_pkg::*;

    tap_state_t state_q;
    tap_state_t state_d;

    ////////////////////////////////////////////////////////////////////////////
    // State register
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge tck_pad_i or posedge trst_pad_i) begin
        if (trst_pad_i) begin
            state_q <= test_logic_reset;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Transition table
    ////////////////////////////////////////////////////////////////////////////
    // Five TMS-high clocks reach test_logic_reset from anywhere
    always_comb begin
        case (state_q)
            test_logic_reset: state_d = tms_pad_i ? test_logic_reset : run_test_idle;
            run_test_idle:    state_d = tms_pad_i ? select_dr_scan   : run_test_idle;

            // DR column
            select_dr_scan:   state_d = tms_pad_i ? select_ir_scan   : capture_dr;
            capture_dr:       state_d = tms_pad_i ? exit1_dr         : shift_dr;
            shift_dr:         state_d = tms_pad_i ? exit1_dr         : shift_dr;
            exit1_dr:         state_d = tms_pad_i ? update_dr        : pause_dr;
            pause_dr:         state_d = tms_pad_i ? exit2_dr         : pause_dr;
            exit2_dr:         state_d = tms_pad_i ? update_dr        : shift_dr;
            update_dr:        state_d = tms_pad_i ? select_dr_scan   : run_test_idle;

            // IR column
            select_ir_scan:   state_d = tms_pad_i ? test_logic_reset : capture_ir;
            capture_ir:       state_d = tms_pad_i ? exit1_ir         : shift_ir;
            shift_ir:         state_d = tms_pad_i ? exit1_ir         : shift_ir;
            exit1_ir:         state_d = tms_pad_i ? update_ir        : pause_ir;
            pause_ir:         state_d = tms_pad_i ? exit2_ir         : pause_ir;
            exit2_ir:         state_d = tms_pad_i ? update_ir        : shift_ir;
            update_ir:        state_d = tms_pad_i ? select_dr_scan   : run_test_idle;

            default:          state_d = test_logic_reset;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Strobe decode
    ////////////////////////////////////////////////////////////////////////////
    // Straight from the state register, no extra latency
    assign state.tlr        = (state_q == test_logic_reset);
    assign state.capture_ir = (state_q == capture_ir);
    assign state.shift_ir   = (state_q == shift_ir);
    assign state.update_ir  = (state_q == update_ir);
    assign state.capture_dr = (state_q == capture_dr);
    assign state.shift_dr   = (state_q == shift_dr);
    assign state.pause_dr   = (state_q == pause_dr);
    assign state.update_dr  = (state_q == update_dr);

    // Register blocks rely on never seeing two actions in one cycle
    a_strobes_onehot0: assert property (
        @(posedge tck_pad_i) disable iff (trst_pad_i)
        $onehot0({state.tlr, state.capture_ir, state.shift_ir, state.update_ir,
                  state.capture_dr, state.shift_dr, state.pause_dr, state.update_dr})
    );

endmodule

`default_nettype wire

// File: tap/tap_ir.sv
////////////////////////////////////////////////////////////////////////////
// Instruction register with capture/shift stage, latched instruction
// and one-hot decode of the active instruction
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tap_ir (
    input  logic                 tck_pad_i,
    input  logic                 trst_pad_i,
    input  logic                 tdi_pad_i,
    tap_state_if.reg_mp          state,
    output jtag_pkg::tap_instr_t active_instr,
    output logic                 ir_tdo,
    output logic                 idcode_sel,
    output logic                 bypass_sel,
    output logic                 extest_select_o,
    output logic                 sample_preload_select_o,
    output logic                 debug_select_o
);

    import jtag_pkg::*;

    tap_instr_t ir_shift_q;

    ////////////////////////////////////////////////////////////////////////////
    // Capture / shift stage
    ////////////////////////////////////////////////////////////////////////////
    // Shifts LSB first, TDI enters at the MSB
    always_ff @(posedge tck_pad_i or posedge trst_pad_i) begin
        if (trst_pad_i) begin
            ir_shift_q <= '0;
        end else if (state.capture_ir) begin
            ir_shift_q <= IR_CAPTURE_VALUE;
        end else if (state.shift_ir) begin
            ir_shift_q <= {tdi_pad_i, ir_shift_q[IR_LENGTH-1:1]};
        end
    end

    // Retimed to falling edge for the TDO mux
    always_ff @(negedge tck_pad_i or posedge trst_pad_i) begin
        if (trst_pad_i) begin
            ir_tdo <= 1'b0;
        end else begin
            ir_tdo <= ir_shift_q[0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Latched instruction
    ////////////////////////////////////////////////////////////////////////////
    // IDCODE comes back on any reset, TRST or test_logic_reset
    always_ff @(posedge tck_pad_i or posedge trst_pad_i) begin
        if (trst_pad_i) begin
            active_instr <= INSTR_IDCODE;
        end else if (state.tlr) begin
            active_instr <= INSTR_IDCODE;
        end else if (state.update_ir) begin
            active_instr <= ir_shift_q;
        end
    end

    // Decode, unknown codes fall through to bypass
    always_comb begin
        extest_select_o         = 1'b0;
        sample_preload_select_o = 1'b0;
        idcode_sel              = 1'b0;
        debug_select_o          = 1'b0;
        bypass_sel              = 1'b0;
        case (active_instr)
            INSTR_EXTEST:         extest_select_o = 1'b1;
            INSTR_SAMPLE_PRELOAD: sample_preload_select_o = 1'b1;
            INSTR_IDCODE:         idcode_sel = 1'b1;
            INSTR_DEBUG:          debug_select_o = 1'b1;
            default:              bypass_sel = 1'b1;
        endcase
    end

    a_select_onehot: assert property (
        @(posedge tck_pad_i) disable iff (trst_pad_i)
        $onehot({extest_select_o, sample_preload_select_o, idcode_sel,
                 debug_select_o, bypass_sel})
    );

endmodule

`default_nettype wire

// File: tap/tap_dr_mux.sv
////////////////////////////////////////////////////////////////////////////
// IDCODE and BYPASS data registers plus the falling-edge TDO path
// Picks IR, internal DR or an external chain and drives the pad enable
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tap_dr_mux (
    input  logic                 tck_pad_i,
    input  logic                 trst_pad_i,
    input  logic                 tdi_pad_i,
    tap_state_if.reg_mp          state,
    input  jtag_pkg::tap_instr_t active_instr,
    input  logic                 ir_tdo,
    input  logic                 idcode_sel,
    input  logic                 bypass_sel,
    input  logic                 debug_tdi_i,
    input  logic                 bs_chain_tdi_i,
    output logic                 tdo_pad_o,
    output logic                 tdo_padoe_o
);

    import jtag_pkg::*;

    idcode_t    idcode_q;
    logic       bypass_q;
    logic       idcode_tdo;
    logic       bypass_tdo;
    logic       shift_ir_neg;
    tap_instr_t instr_neg;

    ////////////////////////////////////////////////////////////////////////////
    // Rising edge data registers
    ////////////////////////////////////////////////////////////////////////////
    // Reloads whenever it is not being shifted out
    always_ff @(posedge tck_pad_i or posedge trst_pad_i) begin
        if (trst_pad_i) begin
            idcode_q <= IDCODE_VALUE;
        end else if (idcode_sel && state.shift_dr) begin
            idcode_q <= {tdi_pad_i, idcode_q[IDCODE_LENGTH-1:1]};
        end else begin
            idcode_q <= IDCODE_VALUE;
        end
    end

    // Single bit bypass register that shifts only under a bypass code
    always_ff @(posedge tck_pad_i or posedge trst_pad_i) begin
        if (trst_pad_i) begin
            bypass_q <= 1'b0;
        end else if (state.capture_dr) begin
            bypass_q <= 1'b0;
        end else if (state.shift_dr && bypass_sel) begin
            bypass_q <= tdi_pad_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Falling edge copies
    ////////////////////////////////////////////////////////////////////////////
    // Everything steering TDO settles half a cycle after the shift
    always_ff @(negedge tck_pad_i or posedge trst_pad_i) begin
        if (trst_pad_i) begin
            idcode_tdo   <= 1'b0;
            bypass_tdo   <= 1'b0;
            shift_ir_neg <= 1'b0;
            instr_neg    <= INSTR_IDCODE;
            tdo_padoe_o  <= 1'b0;
        end else begin
            idcode_tdo   <= idcode_q[0];
            bypass_tdo   <= bypass_q;
            shift_ir_neg <= state.shift_ir;
            instr_neg    <= active_instr;
            // Debug chain keeps the pad driven through pause_dr
            tdo_padoe_o  <= state.shift_ir | state.shift_dr |
                            (state.pause_dr & (active_instr == INSTR_DEBUG));
        end
    end

    // TDO source select
    always_comb begin
        if (shift_ir_neg) begin
            tdo_pad_o = ir_tdo;
        end else begin
            case (instr_neg)
                INSTR_IDCODE:         tdo_pad_o = idcode_tdo;
                INSTR_DEBUG:          tdo_pad_o = debug_tdi_i;
                INSTR_EXTEST,
                INSTR_SAMPLE_PRELOAD: tdo_pad_o = bs_chain_tdi_i;
                default:              tdo_pad_o = bypass_tdo;
            endcase
        end
    end

    // Pad must be released right after leaving test_logic_reset
    a_padoe_off_after_tlr: assert property (
        @(posedge tck_pad_i) disable iff (trst_pad_i)
        state.tlr |=> !tdo_padoe_o
    );

endmodule

`default_nettype wire

// File: design/tap_top.sv
////////////////////////////////////////////////////////////////////////////
// JTAG TAP controller top level
// Joins the pads, external chain ports, state machine and register blocks
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tap_top (
    // JTAG pads
    input  logic tck_pad_i,
    input  logic trst_pad_i,
    input  logic tms_pad_i,
    input  logic tdi_pad_i,
    output logic tdo_pad_o,
    output logic tdo_padoe_o,
    // DR state strobes for external chains
    output logic shift_dr_o,
    output logic pause_dr_o,
    output logic update_dr_o,
    output logic capture_dr_o,
    // Chain selects
    output logic extest_select_o,
    output logic sample_preload_select_o,
    output logic debug_select_o,
    // Return data from external chains
    input  logic debug_tdi_i,
    input  logic bs_chain_tdi_i
);

    import jtag_pkg::*;

    tap_instr_t active_instr;
    logic       ir_tdo;
    logic       idcode_sel;
    logic       bypass_sel;

    tap_state_if u_tap_state ();

    tap_fsm u_tap_fsm (
        .tck_pad_i  (tck_pad_i),
        .trst_pad_i (trst_pad_i),
        .tms_pad_i  (tms_pad_i),
        .state      (u_tap_state.fsm_mp)
    );

    tap_ir u_tap_ir (
        .tck_pad_i               (tck_pad_i),
        .trst_pad_i              (trst_pad_i),
        .tdi_pad_i               (tdi_pad_i),
        .state                   (u_tap_state.reg_mp),
        .active_instr            (active_instr),
        .ir_tdo                  (ir_tdo),
        .idcode_sel              (idcode_sel),
        .bypass_sel              (bypass_sel),
        .extest_select_o         (extest_select_o),
        .sample_preload_select_o (sample_preload_select_o),
        .debug_select_o          (debug_select_o)
    );

    tap_dr_mux u_tap_dr_mux (
        .tck_pad_i      (tck_pad_i),
        .trst_pad_i     (trst_pad_i),
        .tdi_pad_i      (tdi_pad_i),
        .state          (u_tap_state.reg_mp),
        .active_instr   (active_instr),
        .ir_tdo         (ir_tdo),
        .idcode_sel     (idcode_sel),
        .bypass_sel     (bypass_sel),
        .debug_tdi_i    (debug_tdi_i),
        .bs_chain_tdi_i (bs_chain_tdi_i),
        .tdo_pad_o      (tdo_pad_o),
        .tdo_padoe_o    (tdo_padoe_o)
    );

    // External chains see the raw state decode
    assign shift_dr_o   = u_tap_state.shift_dr;
    assign pause_dr_o   = u_tap_state.pause_dr;
    assign update_dr_o  = u_tap_state.update_dr;
    assign capture_dr_o = u_tap_state.capture_dr;

endmodule

`default_nettype wire

// File: tests/tap_tb.sv
////////////////////////////////////////////////////////////////////////////
// Self-checking testbench for the JTAG TAP controller
// Random TMS/TDI stimulus compared cycle by cycle against a TAP model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tap_tb;

    import jtag_pkg::*;

    localparam int HALF_PERIOD   = 20;
    localparam int DRIVE_DELAY   = 5;
    localparam int RESET_CYCLES  = 16;
    localparam int RANDOM_CYCLES = 400;
    localparam int NAV_TIMEOUT   = 8;
    localparam int TLR_TIMEOUT   = 8;

    logic tck_pad_i;
    logic trst_pad_i;
    logic tms_pad_i;
    logic tdi_pad_i;
    logic debug_tdi_i;
    logic bs_chain_tdi_i;
    logic tdo_pad_o;
    logic tdo_padoe_o;
    logic shift_dr_o;
    logic pause_dr_o;
    logic update_dr_o;
    logic capture_dr_o;
    logic extest_select_o;
    logic sample_preload_select_o;
    logic debug_select_o;

    // Bookkeeping
    integer seed;
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     test_errors_start;
    bit     aborted;
    string  test_name;
    logic   last_tdo;

    // Reference model
    tap_state_t m_state;
    tap_instr_t m_ir;
    tap_instr_t m_instr;
    idcode_t    m_idcode;
    logic       m_bypass;

    tap_top u_tap_top (.*);

    always #HALF_PERIOD tck_pad_i = ~tck_pad_i;

    ////////////////////////////////////////////////////////////////////////////
    // Model helpers
    ////////////////////////////////////////////////////////////////////////////
    // IEEE 1149.1 transition table
    function automatic tap_state_t tap_next_state(tap_state_t s, logic tms);
        case (s)
            test_logic_reset: return tms ? test_logic_reset : run_test_idle;
            run_test_idle:    return tms ? select_dr_scan   : run_test_idle;
            select_dr_scan:   return tms ? select_ir_scan   : capture_dr;
            capture_dr:       return tms ? exit1_dr         : shift_dr;
            shift_dr:         return tms ? exit1_dr         : shift_dr;
            exit1_dr:         return tms ? update_dr        : pause_dr;
            pause_dr:         return tms ? exit2_dr         : pause_dr;
            exit2_dr:         return tms ? update_dr        : shift_dr;
            update_dr:        return tms ? select_dr_scan   : run_test_idle;
            select_ir_scan:   return tms ? test_logic_reset : capture_ir;
            capture_ir:       return tms ? exit1_ir         : shift_ir;
            shift_ir:         return tms ? exit1_ir         : shift_ir;
            exit1_ir:         return tms ? update_ir        : pause_ir;
            pause_ir:         return tms ? exit2_ir         : pause_ir;
            exit2_ir:         return tms ? update_ir        : shift_ir;
            update_ir:        return tms ? select_dr_scan   : run_test_idle;
            default:          return test_logic_reset;
        endcase
    endfunction

    // Codes with a decode of their own
    function automatic logic is_listed(tap_instr_t c);
        return c inside {INSTR_EXTEST, INSTR_SAMPLE_PRELOAD, INSTR_IDCODE,
                         INSTR_DEBUG, INSTR_BYPASS};
    endfunction

    // BYPASS itself and every unlisted code use the bypass register
    function automatic logic selects_bypass(tap_instr_t c);
        return !(c inside {INSTR_EXTEST, INSTR_SAMPLE_PRELOAD, INSTR_IDCODE,
                           INSTR_DEBUG});
    endfunction

    task automatic pick_unlisted(output tap_instr_t c);
        logic [31:0] rnd;
        rnd = $random(seed);
        c = rnd[3:0];
        // Flipping bit 2 moves every listed code off the list
        if (is_listed(c)) begin
            c = c ^ 4'b0100;
        end
    endtask

    task automatic expect_bit(input string what, input logic exp, input logic act);
        if (!aborted && act !== exp) begin
            errors++;
            $display("error %s %s: expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic expect_word(input string what, input idcode_t exp, input idcode_t act);
        if (!aborted && act !== exp) begin
            errors++;
            $display("error %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One TCK cycle of drive, check just before the rising edge and model step
    ////////////////////////////////////////////////////////////////////////////
    task automatic step_tck(input logic tms, input logic tdi);
        tap_state_t  s;
        logic [31:0] rnd;
        logic        padoe_exp;
        logic        tdo_exp;
        if (!aborted) begin
            rnd = $random(seed);
            tms_pad_i      = tms;
            tdi_pad_i      = tdi;
            debug_tdi_i    = rnd[0];
            bs_chain_tdi_i = rnd[1];
            @(negedge tck_pad_i);
            #(HALF_PERIOD - 1);
            // Pad enabled while shifting, or in pause_dr under DEBUG
            padoe_exp = (m_state == shift_ir) || (m_state == shift_dr) ||
                        (m_state == pause_dr && m_instr == INSTR_DEBUG);
            if (m_state == shift_ir) begin
                tdo_exp = m_ir[0];
            end else if (m_instr == INSTR_IDCODE) begin
                tdo_exp = m_idcode[0];
            end else if (m_instr == INSTR_DEBUG) begin
                tdo_exp = debug_tdi_i;
            end else if (m_instr == INSTR_EXTEST || m_instr == INSTR_SAMPLE_PRELOAD) begin
                tdo_exp = bs_chain_tdi_i;
            end else begin
                tdo_exp = m_bypass;
            end
            expect_bit("capture_dr_o", m_state == capture_dr, capture_dr_o);
            expect_bit("shift_dr_o", m_state == shift_dr, shift_dr_o);
            expect_bit("pause_dr_o", m_state == pause_dr, pause_dr_o);
            expect_bit("update_dr_o", m_state == update_dr, update_dr_o);
            expect_bit("extest_select_o", m_instr == INSTR_EXTEST, extest_select_o);
            expect_bit("sample_preload_select_o", m_instr == INSTR_SAMPLE_PRELOAD,
                       sample_preload_select_o);
            expect_bit("debug_select_o", m_instr == INSTR_DEBUG, debug_select_o);
            expect_bit("tdo_padoe_o", padoe_exp, tdo_padoe_o);
            // TDO only matters while the pad drives it
            if (padoe_exp) begin
                expect_bit("tdo_pad_o", tdo_exp, tdo_pad_o);
            end
            last_tdo = tdo_pad_o;
            @(posedge tck_pad_i);
            #DRIVE_DELAY;
            // Data registers first since they see the old instruction
            s = m_state;
            if (s == shift_dr && m_instr == INSTR_IDCODE) begin
                m_idcode = {tdi, m_idcode[IDCODE_LENGTH-1:1]};
            end else begin
                m_idcode = IDCODE_VALUE;
            end
            if (s == capture_dr) begin
                m_bypass = 1'b0;
            end else if (s == shift_dr && selects_bypass(m_instr)) begin
                m_bypass = tdi;
            end
            if (s == test_logic_reset) begin
                m_instr = INSTR_IDCODE;
            end else if (s == update_ir) begin
                m_instr = m_ir;
            end
            if (s == capture_ir) begin
                m_ir = IR_CAPTURE_VALUE;
            end else if (s == shift_ir) begin
                m_ir = {tdi, m_ir[IR_LENGTH-1:1]};
            end
            m_state = tap_next_state(s, tms);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Navigation and scans
    ////////////////////////////////////////////////////////////////////////////
    task automatic go_to_shift_dr();
        int n;
        n = 0;
        // Only run_test_idle needs TMS high on the way in
        while (shift_dr_o !== 1'b1 && n < NAV_TIMEOUT && !aborted) begin
            step_tck(m_state == run_test_idle, 1'b0);
            n++;
        end
        if (shift_dr_o !== 1'b1 && !aborted) begin
            $display("timeout: TAP did not reach shift_dr within %0d clocks", NAV_TIMEOUT);
            aborted = 1'b1;
        end
    endtask

    task automatic reset_by_tms();
        int clocks;
        clocks = 0;
        while (m_state != test_logic_reset && clocks < TLR_TIMEOUT && !aborted) begin
            step_tck(1'b1, 1'b0);
            clocks++;
        end
        if (m_state != test_logic_reset && !aborted) begin
            $display("timeout: TAP did not reach test_logic_reset with TMS held high");
            aborted = 1'b1;
        end
    endtask

    task automatic return_to_idle();
        reset_by_tms();
        step_tck(1'b0, 1'b0);
    endtask

    // From shift_dr LSB first, ending in run_test_idle
    task automatic shift_dr_bits(input int n, input idcode_t din, output idcode_t dout);
        dout = '0;
        for (int i = 0; i < n; i++) begin
            step_tck(i == n - 1, din[i]);
            dout[i] = last_tdo;
        end
        step_tck(1'b1, 1'b0);
        step_tck(1'b0, 1'b0);
    endtask

    // Starts and ends in run_test_idle
    task automatic load_ir(input tap_instr_t code);
        tap_instr_t captured;
        captured = '0;
        step_tck(1'b1, 1'b0);
        step_tck(1'b1, 1'b0);
        step_tck(1'b0, 1'b0);
        step_tck(1'b0, 1'b0);
        for (int i = 0; i < IR_LENGTH; i++) begin
            step_tck(i == IR_LENGTH - 1, code[i]);
            captured[i] = last_tdo;
        end
        step_tck(1'b1, 1'b0);
        step_tck(1'b0, 1'b0);
        if (!aborted && captured !== IR_CAPTURE_VALUE) begin
            errors++;
            $display("error %s ir capture: expected %b actual %b",
                     test_name, IR_CAPTURE_VALUE, captured);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors_start = errors;
        tests_run++;
    endtask

    task automatic report_result();
        if (aborted) begin
            tests_failed++;
            $display("test %s: stopped by timeout", test_name);
        end else if (errors == test_errors_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d failed checks", test_name, errors - test_errors_start);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic reset_defaults();
        idcode_t din;
        idcode_t dout;
        start_test("reset_defaults");
        expect_bit("capture_dr_o", 1'b0, capture_dr_o);
        expect_bit("shift_dr_o", 1'b0, shift_dr_o);
        expect_bit("pause_dr_o", 1'b0, pause_dr_o);
        expect_bit("update_dr_o", 1'b0, update_dr_o);
        expect_bit("extest_select_o", 1'b0, extest_select_o);
        expect_bit("sample_preload_select_o", 1'b0, sample_preload_select_o);
        expect_bit("debug_select_o", 1'b0, debug_select_o);
        expect_bit("tdo_padoe_o", 1'b0, tdo_padoe_o);
        go_to_shift_dr();
        din = $random(seed);
        shift_dr_bits(IDCODE_LENGTH, din, dout);
        expect_word("idcode", IDCODE_VALUE, dout);
        report_result();
    endtask

    task automatic state_sequencing();
        logic [31:0] rnd;
        start_test("state_sequencing");
        repeat (RANDOM_CYCLES) begin
            rnd = $random(seed);
            step_tck(rnd[0], rnd[1]);
        end
        return_to_idle();
        report_result();
    endtask

    task automatic instruction_load();
        tap_instr_t codes [7];
        start_test("instruction_load");
        codes[0] = INSTR_EXTEST;
        codes[1] = INSTR_SAMPLE_PRELOAD;
        codes[2] = INSTR_IDCODE;
        codes[3] = INSTR_DEBUG;
        codes[4] = INSTR_BYPASS;
        pick_unlisted(codes[5]);
        pick_unlisted(codes[6]);
        for (int i = 0; i < 7; i++) begin
            load_ir(codes[i]);
            expect_bit("extest_select_o", codes[i] == INSTR_EXTEST, extest_select_o);
            expect_bit("sample_preload_select_o", codes[i] == INSTR_SAMPLE_PRELOAD,
                       sample_preload_select_o);
            expect_bit("debug_select_o", codes[i] == INSTR_DEBUG, debug_select_o);
        end
        report_result();
    endtask

    task automatic bypass_path();
        tap_instr_t code;
        idcode_t    din;
        idcode_t    dout;
        start_test("bypass_path");
        for (int k = 0; k < 2; k++) begin
            if (k == 0) begin
                code = INSTR_BYPASS;
            end else begin
                pick_unlisted(code);
            end
            load_ir(code);
            go_to_shift_dr();
            din = $random(seed);
            shift_dr_bits(16, din, dout);
            // One bit of delay with the zero from capture_dr first
            expect_word("bypass stream", (din << 1) & 32'h0000ffff, dout);
        end
        report_result();
    endtask

    task automatic external_chains();
        idcode_t din;
        idcode_t dout;
        start_test("external_chains");
        // Boundary scan chain with TDO checked against bs_chain_tdi_i every shift cycle
        load_ir(INSTR_EXTEST);
        go_to_shift_dr();
        din = $random(seed);
        shift_dr_bits(8, din, dout);
        load_ir(INSTR_SAMPLE_PRELOAD);
        go_to_shift_dr();
        shift_dr_bits(8, din, dout);
        // Debug chain with a stop in pause_dr
        load_ir(INSTR_DEBUG);
        go_to_shift_dr();
        repeat (3) step_tck(1'b0, 1'b1);
        step_tck(1'b1, 1'b0);
        repeat (4) step_tck(1'b0, 1'b0);
        step_tck(1'b1, 1'b0);
        step_tck(1'b1, 1'b0);
        step_tck(1'b0, 1'b0);
        report_result();
    endtask

    task automatic tms_reset();
        logic [31:0] rnd;
        tap_instr_t  code;
        idcode_t     din;
        idcode_t     dout;
        int          walk;
        start_test("tms_reset");
        rnd = $random(seed);
        case (rnd[1:0])
            2'd0:    code = INSTR_EXTEST;
            2'd1:    code = INSTR_SAMPLE_PRELOAD;
            2'd2:    code = INSTR_DEBUG;
            default: code = INSTR_BYPASS;
        endcase
        load_ir(code);
        walk = 5 + (rnd % 16);
        // TDI held high so no update can load IDCODE
        // TMS forced low in select_ir_scan so the walk never reaches reset
        repeat (walk) begin
            rnd = $random(seed);
            step_tck(rnd[0] && m_state != select_ir_scan, 1'b1);
        end
        // Exactly five TMS-high clocks, the readout then shows IDCODE is back
        repeat (5) step_tck(1'b1, 1'b0);
        go_to_shift_dr();
        din = $random(seed);
        shift_dr_bits(IDCODE_LENGTH, din, dout);
        expect_word("idcode after TMS reset", IDCODE_VALUE, dout);
        report_result();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        seed           = 32'h7cd9;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        aborted        = 1'b0;
        last_tdo       = 1'b0;
        tck_pad_i      = 1'b0;
        trst_pad_i     = 1'b1;
        tms_pad_i      = 1'b1;
        tdi_pad_i      = 1'b0;
        debug_tdi_i    = 1'b0;
        bs_chain_tdi_i = 1'b0;
        m_state        = test_logic_reset;
        m_ir           = '0;
        m_instr        = INSTR_IDCODE;
        m_idcode       = IDCODE_VALUE;
        m_bypass       = 1'b0;
        repeat (RESET_CYCLES) @(posedge tck_pad_i);
        #DRIVE_DELAY;
        trst_pad_i = 1'b0;

        reset_defaults();
        state_sequencing();
        instruction_load();
        bypass_path();
        external_chains();
        tms_reset();

        $display("%0d tests run, %0d failed, %0d failed checks",
                 tests_run, tests_failed, errors);
        if (errors == 0 && !aborted) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
common/jtag_pkg.sv
common/tap_state_if.sv
tap/tap_fsm.sv
tap/tap_ir.sv
tap/tap_dr_mux.sv
design/tap_top.sv
tests/tap_tb.sv

// File: Makefile
# Verilator build and run for the JTAG TAP controller testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tap_tb
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# The run fails unless the log holds the pass line
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
